// ==== Makefile ====
SIM       := verilator
TOP       := vpu_dispatch_tb
FILELIST  := vpu_dispatch.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Verification passed

SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/vpu_dispatch_tb.sv ====
`timescale 1ns/100ps

module vpu_dispatch_tb;

   localparam int GROUPS     = vpu_pkg::W_PORTS_NUM;
   localparam int WAIT_LIMIT = 400;

   logic                                         clk;
   logic                                         rstn;
   logic                                         instr_vld_i;
   logic [31:0]                                  instr_i;
   logic [vpu_pkg::TAG_W-1:0]                    tag_i;
   logic                                         busy;
   logic [GROUPS-1:0]                            done;
   logic [GROUPS-1:0][vpu_pkg::TAG_W-1:0]        done_tag;
   logic                                         illegal;
   logic [vpu_pkg::TAG_W-1:0]                    illegal_tag;
   logic [vpu_pkg::R_SEL_W-1:0]                  op3_sel;
   logic                                         alloc_vld;

   // expected completions are kept as one in-order list per group
   logic [vpu_pkg::TAG_W-1:0]                    grp_fifo [GROUPS][256];
   int                                           grp_wr [GROUPS];
   int                                           grp_rd [GROUPS];
   logic [vpu_pkg::TAG_W-1:0]                    illegal_fifo [$];
   int                                           exp_group [256];
   int                                           exp_latency [256];
   int                                           strobe_cycle [256];
   int                                           legal_cnt;
   int                                           issued_cnt;
   int                                           done_cnt;
   int                                           illegal_cnt;
   int                                           alloc_cnt;
   int                                           cycle_cnt;
   int                                           next_tag;
   logic [31:0]                                  rng;
   string                                        test_name;
   logic                                         busy_seen;
   logic                                         op3_pending;
   logic [vpu_pkg::R_SEL_W-1:0]                  op3_exp;

   vpu_dispatch_top dut (
      .clk               (clk),
      .rstn              (rstn),
      .instr_vld_i       (instr_vld_i),
      .instr_i           (instr_i),
      .tag_i             (tag_i),
      .busy_o            (busy),
      .done_o            (done),
      .done_tag_o        (done_tag),
      .illegal_o         (illegal),
      .illegal_tag_o     (illegal_tag),
      .op3_port_sel_o    (op3_sel),
      .alloc_port_vld_o  (alloc_vld)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // class k sits at the base opcode plus k and any other top byte is illegal
   function automatic int expected_class(input logic [7:0] top);
      int cls;
      cls = -1;
      for (int k = 0; k < vpu_pkg::CLASS_NUM; k++)
      begin
         if (top == vpu_pkg::CLASS_OPCODE_BASE + 8'(k))
            cls = k;
      end
      return cls;
   endfunction

   function automatic logic [7:0] random_opcode();
      logic [31:0] r;
      r = next_random();
      if (r[3:0] < 4'd13)
         return vpu_pkg::CLASS_OPCODE_BASE + 8'(r[31:8] % 12);
      else
         return vpu_pkg::CLASS_OPCODE_BASE + 8'd12 + 8'(r[31:8] % 64);
   endfunction

   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_tag(input string what, input logic [vpu_pkg::TAG_W-1:0] exp,
                            input logic [vpu_pkg::TAG_W-1:0] act);
      if (exp !== act)
         stop_with_error($sformatf("CHECK FAILED %s: %s expected %0h actual %0h",
                                   test_name, what, exp, act));
   endtask

   task automatic check_group(input string what, input logic [vpu_pkg::R_SEL_W-1:0] exp,
                              input logic [vpu_pkg::R_SEL_W-1:0] act);
      if (exp !== act)
         stop_with_error($sformatf("CHECK FAILED %s: %s expected %0d actual %0d",
                                   test_name, what, exp, act));
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (exp != act)
         stop_with_error($sformatf("CHECK FAILED %s: %s expected %0d actual %0d",
                                   test_name, what, exp, act));
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #2;
      end
   endtask

   // one strobe followed by at least one quiet cycle keeps the decoder from overrunning a full queue
   task automatic issue(input logic [7:0] top, input logic [vpu_pkg::VREG_W-1:0] vreg);
      int                          wait_cnt;
      int                          cls;
      int                          g;
      logic [31:0]                 r;
      logic [vpu_pkg::TAG_W-1:0]   tag;
      wait_cnt = 0;
      while (busy)
      begin
         @(posedge clk);
         #2;
         wait_cnt++;
         if (wait_cnt > WAIT_LIMIT)
            stop_with_error("busy_o stayed high and the queue never drained");
      end
      tag = vpu_pkg::TAG_W'(next_tag);
      cls = expected_class(top);
      r = next_random();
      strobe_cycle[tag] = cycle_cnt;
      if (cls < 0)
         illegal_fifo.push_back(tag);
      else
      begin
         g = legal_cnt % GROUPS;
         exp_group[tag] = g;
         exp_latency[tag] = cls + 2;
         grp_fifo[g][grp_wr[g] % 256] = tag;
         grp_wr[g]++;
         legal_cnt++;
      end
      issued_cnt++;
      next_tag++;
      instr_vld_i = 1'b1;
      instr_i = {top, r[11:0], vreg, r[18:12]};
      tag_i = tag;
      @(posedge clk);
      #2;
      instr_vld_i = 1'b0;
      @(posedge clk);
      #2;
   endtask

   task automatic wait_drain();
      int wait_cnt;
      wait_cnt = 0;
      while (issued_cnt != done_cnt + illegal_cnt)
      begin
         @(posedge clk);
         #2;
         wait_cnt++;
         if (wait_cnt > WAIT_LIMIT)
            stop_with_error("outstanding instructions never completed");
      end
      // a group that just finished needs one more edge before it counts as free
      idle_cycles(2);
   endtask

   always @(negedge clk)
   begin : compare
      logic [vpu_pkg::TAG_W-1:0] exp_tag;
      if (rstn)
      begin
         if (busy)
            busy_seen = 1'b1;
         if (alloc_vld)
            alloc_cnt++;
         if (illegal)
         begin
            if (illegal_fifo.size() == 0)
               stop_with_error("illegal_o pulsed with no illegal instruction outstanding");
            else
            begin
               check_tag("illegal tag", illegal_fifo.pop_front(), illegal_tag);
               illegal_cnt++;
            end
         end
         for (int g = 0; g < GROUPS; g++)
         begin
            if (done[g])
            begin
               if (grp_rd[g] == grp_wr[g])
                  stop_with_error($sformatf("group %0d completed with nothing expected", g));
               else
               begin
                  check_group("completing group", vpu_pkg::R_SEL_W'(exp_group[done_tag[g]]),
                              vpu_pkg::R_SEL_W'(g));
                  exp_tag = grp_fifo[g][grp_rd[g] % 256];
                  grp_rd[g]++;
                  check_tag($sformatf("done tag of group %0d", g), exp_tag, done_tag[g]);
                  if (cycle_cnt - strobe_cycle[done_tag[g]] < exp_latency[done_tag[g]])
                     stop_with_error($sformatf("tag %0h completed sooner than its class latency",
                                               done_tag[g]));
                  done_cnt++;
               end
            end
         end
         if (op3_pending && alloc_vld)
         begin
            check_group("third operand read port", op3_exp, op3_sel);
            op3_pending = 1'b0;
         end
      end
   end

   initial
   begin
      rng = 32'hcdfa;
      rstn = 1'b0;
      instr_vld_i = 1'b0;
      instr_i = '0;
      tag_i = '0;
      cycle_cnt = 0;
      legal_cnt = 0;
      issued_cnt = 0;
      done_cnt = 0;
      illegal_cnt = 0;
      alloc_cnt = 0;
      next_tag = 0;
      busy_seen = 1'b0;
      op3_pending = 1'b0;
      op3_exp = '0;
      for (int g = 0; g < GROUPS; g++)
      begin
         grp_wr[g] = 0;
         grp_rd[g] = 0;
      end

      test_name = "reset";
      repeat (2) @(posedge clk);
      #2;
      rstn = 1'b1;
      repeat (5)
      begin
         if (done != '0 || illegal || alloc_vld || busy)
            stop_with_error("an output was active right after reset");
         @(posedge clk);
         #2;
      end

      test_name = "illegal";
      issue(8'hff, 5'd3);
      issue(8'h00, 5'd9);
      wait_drain();

      test_name = "latency";
      for (int k = 0; k < vpu_pkg::CLASS_NUM; k++)
      begin
         issue(vpu_pkg::CLASS_OPCODE_BASE + 8'(k), vpu_pkg::VREG_W'(2 * k));
         wait_drain();
      end

      // with every group free the read port is group 0, or group 1 when the pointer is at 0
      test_name = "op3 port";
      for (int i = 0; i < GROUPS; i++)
      begin
         op3_exp = (legal_cnt % GROUPS == 0) ? 3'd1 : 3'd0;
         op3_pending = 1'b1;
         issue(vpu_pkg::CLASS_OPCODE_BASE + 8'(vpu_pkg::CLASS_MVV_OP3), 5'd4);
         wait_drain();
         if (op3_pending)
            stop_with_error("no allocation was seen for the three-operand instruction");
      end

      test_name = "random";
      for (int i = 0; i < 60; i++)
      begin
         logic [7:0]                  top;
         logic [31:0]                 r;
         logic [vpu_pkg::VREG_W-1:0]  vreg;
         top = random_opcode();
         r = next_random();
         vreg = r[4:0];
         // an odd register group would never get a start address
         if (expected_class(top) == int'(vpu_pkg::CLASS_MVV_OP3))
            vreg[0] = 1'b0;
         issue(top, vreg);
         idle_cycles(int'(r[9:8] % 3));
      end
      wait_drain();

      test_name = "burst";
      for (int i = 0; i < 32; i++)
      begin
         issue(vpu_pkg::CLASS_OPCODE_BASE + 8'(vpu_pkg::CLASS_CFG), 5'(next_random()));
      end
      wait_drain();

      test_name = "totals";
      check_count("allocations of legal instructions", legal_cnt, alloc_cnt);
      if (!busy_seen)
         stop_with_error("busy_o never rose while the queue was being filled");
      else
      begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
   (
   input  logic                               clk,
   input  logic                               rstn,

   input  logic                               instr_vld_i,
   input  logic [31:0]                        instr_i,
   input  logic [vpu_pkg::TAG_W-1:0]          tag_i,

   output logic                               dec_vld_o,
   output vpu_pkg::instr_class_e              dec_class_o,
   output logic [vpu_pkg::VREG_W-1:0]         dec_vreg_o,
   output logic [vpu_pkg::TAG_W-1:0]          dec_tag_o,

   output logic                               illegal_o,
   output logic [vpu_pkg::TAG_W-1:0]          illegal_tag_o
   );

   logic                              vld_q;
   logic [7:0]                        opcode_q;
   logic [vpu_pkg::VREG_W-1:0]        vreg_q;
   logic [vpu_pkg::TAG_W-1:0]         tag_q;
   logic [7:0]                        class_ofs;
   logic                              legal;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_q <= 1'b0;
      end
      else
      begin
         vld_q <= instr_vld_i;
      end
   end

   // only the fields that matter downstream are kept
   always_ff @(posedge clk)
   begin
      if (instr_vld_i)
      begin
         opcode_q <= instr_i[31:24];
         vreg_q   <= instr_i[11:7];
         tag_q    <= tag_i;
      end
   end

   // top byte is an offset from the base opcode, anything past the last class is illegal
   assign class_ofs = opcode_q - vpu_pkg::CLASS_OPCODE_BASE;
   assign legal     = class_ofs < 8'(vpu_pkg::CLASS_NUM);

   assign dec_vld_o   = vld_q && legal;
   assign dec_class_o = vpu_pkg::instr_class_e'(class_ofs[3:0]);
   assign dec_vreg_o  = vreg_q;
   assign dec_tag_o   = tag_q;

   // an illegal word is reported once and goes no further
   assign illegal_o     = vld_q && !legal;
   assign illegal_tag_o = tag_q;

endmodule

// ==== rtl/instr_queue.sv ====
`timescale 1ns/100ps

module instr_queue
   (
   input  logic                                clk,
   input  logic                                rstn,

   input  logic                                wr_i,
   input  vpu_pkg::instr_class_e               class_i,
   input  logic [vpu_pkg::VREG_W-1:0]          vreg_i,
   input  logic [vpu_pkg::TAG_W-1:0]           tag_i,
   output logic                                full_o,

   output logic                                vld_o,
   output logic [vpu_pkg::CLASS_NUM-1:0]       instr_vld_o,
   output logic                                vrf_starting_addr_vld_o,
   output logic [vpu_pkg::TAG_W-1:0]           tag_o,
   output vpu_pkg::instr_class_e               class_o,
   input  logic                                pop_i
   );

   vpu_pkg::instr_class_e             class_mem [vpu_pkg::QUEUE_DEPTH];
   logic [vpu_pkg::VREG_W-1:0]        vreg_mem  [vpu_pkg::QUEUE_DEPTH];
   logic [vpu_pkg::TAG_W-1:0]         tag_mem   [vpu_pkg::QUEUE_DEPTH];
   logic [vpu_pkg::QUEUE_PTR_W-1:0]   wr_ptr_q;
   logic [vpu_pkg::QUEUE_PTR_W-1:0]   rd_ptr_q;
   logic [vpu_pkg::QUEUE_PTR_W:0]     count_q;
   logic [vpu_pkg::VREG_W-1:0]        head_vreg;
   logic                              push;
   logic                              pop;

   assign full_o = count_q == (vpu_pkg::QUEUE_PTR_W+1)'(vpu_pkg::QUEUE_DEPTH);
   assign vld_o  = count_q != '0;
   assign push   = wr_i && !full_o;
   assign pop    = pop_i && vld_o;

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         class_mem[wr_ptr_q] <= class_i;
         vreg_mem[wr_ptr_q]  <= vreg_i;
         tag_mem[wr_ptr_q]   <= tag_i;
      end
   end

   // pointers wrap naturally since the depth is a power of two
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

   assign class_o   = class_mem[rd_ptr_q];
   assign tag_o     = tag_mem[rd_ptr_q];
   assign head_vreg = vreg_mem[rd_ptr_q];

   assign instr_vld_o = vld_o ? (vpu_pkg::CLASS_NUM'(1) << class_o) : '0;

   // three-operand instructions need an even register group to start from
   assign vrf_starting_addr_vld_o = !head_vreg[0] || (class_o != vpu_pkg::CLASS_MVV_OP3);

endmodule

// ==== rtl/port_allocate_unit.sv ====
`timescale 1ns/100ps

module port_allocate_unit
   (
   input  logic                                 clk,
   input  logic                                 rstn,

   output logic [vpu_pkg::CLASS_NUM-1:0]        instr_rdy_o,
   input  logic [vpu_pkg::CLASS_NUM-1:0]        instr_vld_i,
   input  logic                                 vrf_starting_addr_vld_i,
   output logic [vpu_pkg::W_PORTS_NUM-1:0]      start_o,
   input  logic [vpu_pkg::W_PORTS_NUM-1:0]      port_rdy_i,
   output logic [vpu_pkg::R_SEL_W-1:0]          op3_port_sel_o,

   output logic                                 alloc_port_vld_o
   );

   logic [vpu_pkg::W_SEL_W-1:0]       ptr_q;
   logic [vpu_pkg::W_SEL_W-1:0]       ptr_next;
   logic [vpu_pkg::W_PORTS_NUM-1:0]   port_status_q;
   logic                              op3_instr;

   assign op3_instr = instr_vld_i[vpu_pkg::CLASS_MVV_OP3];

   // round-robin pointer only moves once the pointed group has actually taken the start
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ptr_q <= '0;
      end
      else
      begin
         if (start_o[ptr_q] && port_rdy_i[ptr_q])
            ptr_q <= ptr_next;
      end
   end

   assign ptr_next = ptr_q + 1'b1;

   // the head is popped only when the pointed group can really take it
   assign alloc_port_vld_o = ((instr_rdy_o & instr_vld_i) != '0) && vrf_starting_addr_vld_i &&
                             port_status_q[ptr_q];

   always_comb
   begin
      for (int i = 0; i < vpu_pkg::W_PORTS_NUM; i++)
      begin
         start_o[i] = alloc_port_vld_o && (i == int'(ptr_q));
      end
   end

   // a grant or a third-operand reservation wins over the ready level for one edge
   generate
      for (genvar i = 0; i < vpu_pkg::W_PORTS_NUM; i++)
      begin : g_status
         always_ff @(posedge clk)
         begin
            if (!rstn)
            begin
               port_status_q[i] <= 1'b1;
            end
            else if (start_o[i] ||
                     (alloc_port_vld_o && op3_instr && op3_port_sel_o == i))
            begin
               port_status_q[i] <= 1'b0;
            end
            else if (port_rdy_i[i])
            begin
               port_status_q[i] <= 1'b1;
            end
         end
      end
   endgenerate

   // walking down leaves the lowest free index other than the pointer
   always_comb
   begin
      op3_port_sel_o = '0;
      for (int i = vpu_pkg::W_PORTS_NUM-1; i >= 0; i--)
      begin
         if (port_status_q[i] && i != int'(ptr_q))
            op3_port_sel_o = vpu_pkg::R_SEL_W'(i);
      end
   end

   assign instr_rdy_o = {vpu_pkg::CLASS_NUM{port_status_q != '0}};

endmodule

// ==== rtl/vpu_dispatch_top.sv ====
`timescale 1ns/100ps

module vpu_dispatch_top
   (
   input  logic                                                clk,
   input  logic                                                rstn,

   input  logic                                                instr_vld_i,
   input  logic [31:0]                                         instr_i,
   input  logic [vpu_pkg::TAG_W-1:0]                           tag_i,
   output logic                                                busy_o,

   output logic [vpu_pkg::W_PORTS_NUM-1:0]                     done_o,
   output logic [vpu_pkg::W_PORTS_NUM-1:0][vpu_pkg::TAG_W-1:0] done_tag_o,

   output logic                                                illegal_o,
   output logic [vpu_pkg::TAG_W-1:0]                           illegal_tag_o,

   output logic [vpu_pkg::R_SEL_W-1:0]                         op3_port_sel_o,
   output logic                                                alloc_port_vld_o
   );

   logic                              dec_vld;
   vpu_pkg::instr_class_e             dec_class;
   logic [vpu_pkg::VREG_W-1:0]        dec_vreg;
   logic [vpu_pkg::TAG_W-1:0]         dec_tag;

   logic                              q_vld;
   logic [vpu_pkg::CLASS_NUM-1:0]     q_instr_vld;
   logic                              q_addr_vld;
   logic [vpu_pkg::TAG_W-1:0]         q_tag;
   vpu_pkg::instr_class_e             q_class;

   logic [vpu_pkg::W_PORTS_NUM-1:0]   start;
   logic [vpu_pkg::W_PORTS_NUM-1:0]   port_rdy;

   instr_decoder u_decoder (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld_i),
      .instr_i        (instr_i),
      .tag_i          (tag_i),
      .dec_vld_o      (dec_vld),
      .dec_class_o    (dec_class),
      .dec_vreg_o     (dec_vreg),
      .dec_tag_o      (dec_tag),
      .illegal_o      (illegal_o),
      .illegal_tag_o  (illegal_tag_o)
   );

   instr_queue u_queue (
      .clk                      (clk),
      .rstn                     (rstn),
      .wr_i                     (dec_vld),
      .class_i                  (dec_class),
      .vreg_i                   (dec_vreg),
      .tag_i                    (dec_tag),
      .full_o                   (busy_o),
      .vld_o                    (q_vld),
      .instr_vld_o              (q_instr_vld),
      .vrf_starting_addr_vld_o  (q_addr_vld),
      .tag_o                    (q_tag),
      .class_o                  (q_class),
      .pop_i                    (alloc_port_vld_o && q_vld)
   );

   // instr_rdy is already folded into the allocation decision inside the allocator
   port_allocate_unit u_alloc (
      .clk                      (clk),
      .rstn                     (rstn),
      .instr_rdy_o              (),
      .instr_vld_i              (q_instr_vld),
      .vrf_starting_addr_vld_i  (q_addr_vld),
      .start_o                  (start),
      .port_rdy_i               (port_rdy),
      .op3_port_sel_o           (op3_port_sel_o),
      .alloc_port_vld_o         (alloc_port_vld_o)
   );

   // head class and tag go to every group, only the started one latches them
   generate
      for (genvar g = 0; g < vpu_pkg::W_PORTS_NUM; g++)
      begin : g_port_group
         vrf_port_group u_group (
            .clk         (clk),
            .rstn        (rstn),
            .start_i     (start[g]),
            .class_i     (q_class),
            .tag_i       (q_tag),
            .port_rdy_o  (port_rdy[g]),
            .done_o      (done_o[g]),
            .done_tag_o  (done_tag_o[g])
         );
      end
   endgenerate

endmodule

// ==== rtl/vpu_pkg.sv ====
package vpu_pkg;

   localparam int R_PORTS_NUM = 8;
   localparam int W_PORTS_NUM = 4;
   localparam int QUEUE_DEPTH = 8;
   localparam int TAG_W       = 8;
   localparam int VREG_W      = 5;
   localparam int CLASS_NUM   = 12;

   localparam int R_SEL_W     = $clog2(R_PORTS_NUM);
   localparam int W_SEL_W     = $clog2(W_PORTS_NUM);
   localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

   // class 0 has this top byte and the other classes follow in order
   localparam logic [7:0] CLASS_OPCODE_BASE = 8'h50;

   typedef enum logic [3:0] {
      CLASS_MVV_ALU = 4'd0,
      CLASS_MVV_OP3 = 4'd1,
      CLASS_MVX_ALU = 4'd2,
      CLASS_MVI_ALU = 4'd3,
      CLASS_MUL     = 4'd4,
      CLASS_DIV     = 4'd5,
      CLASS_RED     = 4'd6,
      CLASS_PERM    = 4'd7,
      CLASS_LOAD    = 4'd8,
      CLASS_STORE   = 4'd9,
      CLASS_MASK    = 4'd10,
      CLASS_CFG     = 4'd11
   } instr_class_e;

   // busy cycles of a write-port group for one instruction of the class
   function automatic logic [3:0] class_latency(input instr_class_e cls);
      return 4'(cls) + 4'd2;
   endfunction

endpackage

// ==== rtl/vrf_port_group.sv ====
`timescale 1ns/100ps

module vrf_port_group
   (
   input  logic                          clk,
   input  logic                          rstn,

   input  logic                          start_i,
   input  vpu_pkg::instr_class_e         class_i,
   input  logic [vpu_pkg::TAG_W-1:0]     tag_i,

   output logic                          port_rdy_o,
   output logic                          done_o,
   output logic [vpu_pkg::TAG_W-1:0]     done_tag_o
   );

   logic                          busy_q;
   logic [3:0]                    cnt_q;
   logic [3:0]                    latency;
   logic [vpu_pkg::TAG_W-1:0]     tag_q;

   assign latency = vpu_pkg::class_latency(class_i);

   // the count starts one below the latency because the start cycle is already spent
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end
      else
      begin
         if (start_i)
         begin
            busy_q <= 1'b1;
            cnt_q  <= latency - 4'd1;
         end
         else if (busy_q)
         begin
            if (cnt_q == '0)
               busy_q <= 1'b0;
            else
               cnt_q <= cnt_q - 4'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_i)
      begin
         tag_q <= tag_i;
      end
   end

   assign done_o     = busy_q && (cnt_q == '0);
   assign done_tag_o = tag_q;

   // ready again in the done cycle, so the allocator sees it one edge later
   assign port_rdy_o = !busy_q || (cnt_q == '0);

endmodule

// ==== vpu_dispatch.f ====
rtl/vpu_pkg.sv
rtl/instr_decoder.sv
rtl/instr_queue.sv
rtl/port_allocate_unit.sv
rtl/vrf_port_group.sv
rtl/vpu_dispatch_top.sv
dv/vpu_dispatch_tb.sv
